//--- flist.f
src/soc_pkg.sv
src/bus_ifs.sv
src/dbus_decode.sv
src/gpio_port.sv
src/uart_tx.sv
src/flash_window.sv
src/fetch_arb.sv
src/spi_flash_reader.sv
src/soc_periph_top.sv
verification/spi_flash_model.sv
verification/tb_soc_periph.sv

//--- src/bus_ifs.sv
// Data and fetch bus interfaces
`timescale 1ns/1ps
`default_nettype none

interface data_bus_if;
    soc_pkg::bus_addr_t adr;
    soc_pkg::bus_data_t dat;
    soc_pkg::bus_sel_t  sel;
    logic               we;
    logic               cyc;
    logic               ack;
    soc_pkg::bus_data_t rdt;

    modport host   (output adr, dat, sel, we, cyc, input  ack, rdt);
    modport device (input  adr, dat, sel, we, cyc, output ack, rdt);
endinterface

// Read-only bus for instruction and flash fetches
interface fetch_bus_if;
    soc_pkg::bus_addr_t adr;
    logic               cyc;
    logic               ack;
    soc_pkg::bus_data_t rdt;

    modport requester (output adr, cyc, input  ack, rdt);
    modport responder (input  adr, cyc, output ack, rdt);
endinterface

`default_nettype wire

//--- src/dbus_decode.sv
// Data bus address decoder
`timescale 1ns/1ps
`default_nettype none

module dbus_decode (
    input wire logic    ck,
    input wire logic    RESET_LOOP,
    data_bus_if.device  i_host,
    data_bus_if.host    o_gpio_bus,
    data_bus_if.host    o_uart_bus,
    data_bus_if.host    o_flash_bus
);

    logic hit_gpio;
    logic hit_uart;
    logic hit_flash;
    logic unmapped;
    logic unmapped_ack;

    assign hit_gpio  = i_host.adr[31:24] == soc_pkg::GPIO_BASE;
    assign hit_uart  = i_host.adr[31:24] == soc_pkg::UART_BASE;
    assign hit_flash = i_host.adr[31:24] == soc_pkg::FLASH_BASE;
    assign unmapped  = i_host.cyc && !(hit_gpio || hit_uart || hit_flash);

    // Request fields go to every device, cyc only to the selected one
    assign o_gpio_bus.adr  = i_host.adr;
    assign o_gpio_bus.dat  = i_host.dat;
    assign o_gpio_bus.sel  = i_host.sel;
    assign o_gpio_bus.we   = i_host.we;
    assign o_gpio_bus.cyc  = i_host.cyc && hit_gpio;

    assign o_uart_bus.adr  = i_host.adr;
    assign o_uart_bus.dat  = i_host.dat;
    assign o_uart_bus.sel  = i_host.sel;
    assign o_uart_bus.we   = i_host.we;
    assign o_uart_bus.cyc  = i_host.cyc && hit_uart;

    assign o_flash_bus.adr = i_host.adr;
    assign o_flash_bus.dat = i_host.dat;
    assign o_flash_bus.sel = i_host.sel;
    assign o_flash_bus.we  = i_host.we;
    assign o_flash_bus.cyc = i_host.cyc && hit_flash;

    // Nobody answers here, so close the cycle with zero data
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= unmapped && !unmapped_ack;
        end
    end

    // Idle devices return zero, so an OR merges the replies
    assign i_host.rdt = o_gpio_bus.rdt | o_uart_bus.rdt | o_flash_bus.rdt;
    assign i_host.ack = o_gpio_bus.ack | o_uart_bus.ack | o_flash_bus.ack | unmapped_ack;

endmodule

`default_nettype wire

//--- src/fetch_arb.sv
// Fetch bus priority arbiter
`timescale 1ns/1ps
`default_nettype none

module fetch_arb (
    input wire logic       ck,
    input wire logic       RESET_LOOP,
    fetch_bus_if.responder i_high,
    fetch_bus_if.responder i_low,
    fetch_bus_if.requester o_shared
);

    typedef enum logic [1:0] {
        A_IDLE,
        A_HIGH,
        A_LOW
    } arb_state_t;

    arb_state_t state;
    logic       sel_high;
    logic       sel_low;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            state <= A_IDLE;
        end else begin
            unique case (state)
                A_IDLE: begin
                    // External ibus wins a tie
                    if (i_high.cyc) begin
                        state <= A_HIGH;
                    end else if (i_low.cyc) begin
                        state <= A_LOW;
                    end
                end
                A_HIGH, A_LOW: begin
                    if (o_shared.ack) begin
                        state <= A_IDLE;
                    end
                end
                default: state <= A_IDLE;
            endcase
        end
    end

    assign sel_high = state == A_HIGH;
    assign sel_low  = state == A_LOW;

    assign o_shared.cyc = (sel_high && i_high.cyc) || (sel_low && i_low.cyc);
    assign o_shared.adr = sel_high ? i_high.adr : i_low.adr;

    assign i_high.ack = sel_high && o_shared.ack;
    assign i_low.ack  = sel_low && o_shared.ack;
    assign i_high.rdt = i_high.ack ? o_shared.rdt : '0;
    assign i_low.rdt  = i_low.ack ? o_shared.rdt : '0;

endmodule

`default_nettype wire

//--- src/flash_window.sv
// Flash read window on the data bus
`timescale 1ns/1ps
`default_nettype none

module flash_window (
    input wire logic      ck,
    input wire logic      RESET_LOOP,
    data_bus_if.device    i_bus,
    fetch_bus_if.requester o_fetch
);

    logic                 req_q;
    logic                 ack_q;
    soc_pkg::flash_addr_t fetch_adr;
    soc_pkg::bus_data_t   rdt_q;
    logic                 start_read;

    assign start_read = i_bus.cyc && !i_bus.we && !req_q && !ack_q;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            req_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            // Writes are accepted and dropped
            ack_q <= (i_bus.cyc && i_bus.we && !req_q && !ack_q) ||
                     (req_q && o_fetch.ack);
            if (start_read) begin
                req_q <= 1'b1;
            end else if (o_fetch.ack) begin
                req_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge ck) begin
        if (start_read) begin
            fetch_adr <= soc_pkg::flash_addr_t'(i_bus.adr);
        end
        if (req_q && o_fetch.ack) begin
            rdt_q <= o_fetch.rdt;
        end
    end

    assign o_fetch.cyc = req_q;
    assign o_fetch.adr = soc_pkg::bus_addr_t'(fetch_adr);
    assign i_bus.ack   = ack_q;
    assign i_bus.rdt   = ack_q ? rdt_q : '0;

endmodule

`default_nettype wire

//--- src/gpio_port.sv
// GPIO output register
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
    input  wire logic          ck,
    input  wire logic          RESET_LOOP,
    data_bus_if.device         i_bus,
    output soc_pkg::gpio_t     o_gpio
);

    soc_pkg::gpio_t gpio_q;
    logic           ack_q;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            gpio_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= i_bus.cyc && !ack_q;
            // Only byte lane 0 is backed by storage
            if (i_bus.cyc && !ack_q && i_bus.we && i_bus.sel[0]) begin
                gpio_q <= i_bus.dat[7:0];
            end
        end
    end

    assign i_bus.ack = ack_q;
    assign i_bus.rdt = ack_q ? {24'b0, gpio_q} : '0;
    assign o_gpio    = gpio_q;

endmodule

`default_nettype wire

//--- src/soc_periph_top.sv
// SoC peripheral fabric top
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top (
    input  wire logic               ck,
    input  wire logic               RESET_LOOP,
    // Data bus
    input  wire soc_pkg::bus_addr_t i_dbus_adr,
    input  wire soc_pkg::bus_data_t i_dbus_dat,
    input  wire soc_pkg::bus_sel_t  i_dbus_sel,
    input  wire logic               i_dbus_we,
    input  wire logic               i_dbus_cyc,
    output soc_pkg::bus_data_t      o_dbus_rdt,
    output logic                    o_dbus_ack,
    // Instruction fetch bus
    input  wire soc_pkg::bus_addr_t i_ibus_adr,
    input  wire logic               i_ibus_cyc,
    output soc_pkg::bus_data_t      o_ibus_rdt,
    output logic                    o_ibus_ack,
    // Device pins
    output soc_pkg::gpio_t          o_gpio,
    output logic                    o_uart_tx,
    output logic                    o_flash_sck,
    output logic                    o_flash_cs_n,
    output logic                    o_flash_mosi,
    input  wire logic               i_flash_miso
);

    data_bus_if  host_bus ();
    data_bus_if  gpio_bus ();
    data_bus_if  uart_bus ();
    data_bus_if  flash_bus ();
    fetch_bus_if ibus_bus ();
    fetch_bus_if win_fetch ();
    fetch_bus_if spi_fetch ();

    assign host_bus.adr = i_dbus_adr;
    assign host_bus.dat = i_dbus_dat;
    assign host_bus.sel = i_dbus_sel;
    assign host_bus.we  = i_dbus_we;
    assign host_bus.cyc = i_dbus_cyc;
    assign o_dbus_rdt   = host_bus.rdt;
    assign o_dbus_ack   = host_bus.ack;

    assign ibus_bus.adr = i_ibus_adr;
    assign ibus_bus.cyc = i_ibus_cyc;
    assign o_ibus_rdt   = ibus_bus.rdt;
    assign o_ibus_ack   = ibus_bus.ack;

    dbus_decode u_decode (.ck(ck), .RESET_LOOP(RESET_LOOP), .i_host(host_bus),
        .o_gpio_bus(gpio_bus), .o_uart_bus(uart_bus), .o_flash_bus(flash_bus));

    gpio_port u_gpio (.ck(ck), .RESET_LOOP(RESET_LOOP), .i_bus(gpio_bus), .o_gpio(o_gpio));

    uart_tx u_uart (.ck(ck), .RESET_LOOP(RESET_LOOP), .i_bus(uart_bus), .o_tx(o_uart_tx));

    flash_window u_window (.ck(ck), .RESET_LOOP(RESET_LOOP), .i_bus(flash_bus),
        .o_fetch(win_fetch));

    // CPU fetches take priority over data reads of the flash
    fetch_arb u_arb (.ck(ck), .RESET_LOOP(RESET_LOOP), .i_high(ibus_bus),
        .i_low(win_fetch), .o_shared(spi_fetch));

    spi_flash_reader u_reader (
        .ck         (ck),
        .RESET_LOOP (RESET_LOOP),
        .i_fetch    (spi_fetch),
        .o_sck      (o_flash_sck),
        .o_cs_n     (o_flash_cs_n),
        .o_mosi     (o_flash_mosi),
        .i_miso     (i_flash_miso)
    );

endmodule

`default_nettype wire

//--- src/soc_pkg.sv
// SoC peripheral definitions
`default_nettype none

package soc_pkg;

    // Bus widths
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  bus_sel_t;

    // Peripheral payloads
    typedef logic [7:0]  gpio_t;
    typedef logic [7:0]  uart_byte_t;
    typedef logic [23:0] flash_addr_t;

    // Address map, matched against adr[31:24]
    localparam logic [7:0] GPIO_BASE  = 8'h40;
    localparam logic [7:0] UART_BASE  = 8'h60;
    localparam logic [7:0] FLASH_BASE = 8'h70;

    // Clock cycles per UART bit, short for simulation
    localparam int UART_DIVIDE = 8;

    typedef logic [$clog2(UART_DIVIDE)-1:0] baud_cnt_t;

    // Last count of one bit period
    localparam baud_cnt_t UART_BAUD_LAST = baud_cnt_t'(UART_DIVIDE - 1);

    // Serial flash read opcode
    localparam logic [7:0] FLASH_READ_CMD = 8'h03;

endpackage

`default_nettype wire

//--- src/spi_flash_reader.sv
// SPI flash word reader
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader (
    input  wire logic      ck,
    input  wire logic      RESET_LOOP,
    fetch_bus_if.responder i_fetch,
    output logic           o_sck,
    output logic           o_cs_n,
    output logic           o_mosi,
    input  wire logic      i_miso
);

    typedef enum logic [2:0] {
        F_IDLE,
        F_CMD,
        F_ADDR,
        F_DATA,
        F_DONE
    } flash_state_t;

    flash_state_t       state;
    logic               sck_q;
    logic [5:0]         bit_cnt;
    logic [31:0]        tx_sr;
    soc_pkg::bus_data_t rx_sr;
    logic               active;
    logic               sck_fall;

    assign active   = state inside {F_CMD, F_ADDR, F_DATA};
    // Falling SCK edge ends each bit
    assign sck_fall = active && sck_q;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            state   <= F_IDLE;
            sck_q   <= 1'b0;
            bit_cnt <= '0;
        end else begin
            sck_q <= active ? !sck_q : 1'b0;
            if (sck_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            unique case (state)
                F_IDLE: begin
                    if (i_fetch.cyc) begin
                        state   <= F_CMD;
                        bit_cnt <= '0;
                    end
                end
                F_CMD: begin
                    if (sck_fall && bit_cnt == 6'd7) begin
                        state <= F_ADDR;
                    end
                end
                F_ADDR: begin
                    if (sck_fall && bit_cnt == 6'd31) begin
                        state <= F_DATA;
                    end
                end
                F_DATA: begin
                    if (sck_fall && bit_cnt == 6'd63) begin
                        state <= F_DONE;
                    end
                end
                F_DONE: state <= F_IDLE;
                default: state <= F_IDLE;
            endcase
        end
    end

    // Command and address shift out MSB first
    always_ff @(posedge ck) begin
        if (state == F_IDLE && i_fetch.cyc) begin
            tx_sr <= {soc_pkg::FLASH_READ_CMD, soc_pkg::flash_addr_t'(i_fetch.adr)};
        end else if (sck_fall) begin
            tx_sr <= {tx_sr[30:0], 1'b0};
        end
    end

    // Sample MISO as SCK rises, first byte ends up in bits 31 to 24
    always_ff @(posedge ck) begin
        if (state == F_DATA && !sck_q) begin
            rx_sr <= {rx_sr[30:0], i_miso};
        end
    end

    assign o_sck  = sck_q;
    assign o_cs_n = !active;
    assign o_mosi = tx_sr[31];

    assign i_fetch.ack = state == F_DONE;
    assign i_fetch.rdt = i_fetch.ack ? rx_sr : '0;

endmodule

`default_nettype wire

//--- src/uart_tx.sv
// UART transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic  ck,
    input  wire logic  RESET_LOOP,
    data_bus_if.device i_bus,
    output logic       o_tx
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_t;

    state_t              state;
    soc_pkg::baud_cnt_t  baud_cnt;
    logic [2:0]          bit_cnt;
    soc_pkg::uart_byte_t shift_q;
    logic                ack_q;
    logic                busy;
    logic                baud_tick;

    assign busy      = state != S_IDLE;
    assign baud_tick = baud_cnt == soc_pkg::UART_BAUD_LAST;

    // Reads always complete, writes wait for the line to go idle
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= i_bus.cyc && !ack_q && (!i_bus.we || !busy);
        end
    end

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            state    <= S_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (!busy || baud_tick) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            unique case (state)
                S_IDLE: begin
                    // Frame begins the cycle after the write is acked
                    if (ack_q && i_bus.we) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (baud_tick) begin
                        state   <= S_DATA;
                        bit_cnt <= '0;
                    end
                end
                S_DATA: begin
                    if (baud_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= S_STOP;
                        end
                    end
                end
                S_STOP: begin
                    if (baud_tick) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Payload shifter, LSB goes out first
    always_ff @(posedge ck) begin
        if (state == S_IDLE && ack_q && i_bus.we) begin
            shift_q <= i_bus.dat[7:0];
        end else if (state == S_DATA && baud_tick) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign o_tx = (state == S_START) ? 1'b0 :
                  (state == S_DATA)  ? shift_q[0] : 1'b1;

    assign i_bus.ack = ack_q;
    assign i_bus.rdt = ack_q ? {31'b0, busy} : '0;

endmodule

`default_nettype wire

//--- verification/spi_flash_model.sv
// Behavioral SPI flash
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  wire logic i_sck,
    input  wire logic i_cs_n,
    input  wire logic i_mosi,
    output logic      o_miso,
    output logic      o_bad_cmd
);

    int          bit_n;
    logic [31:0] cmd_adr;
    logic [31:0] word;

    initial begin
        bit_n     = 0;
        cmd_adr   = '0;
        word      = '0;
        o_miso    = 1'b0;
        o_bad_cmd = 1'b0;
    end

    // Each select starts a new command
    always @(negedge i_cs_n) begin
        bit_n = 0;
    end

    // Opcode and address arrive MSB first on the rising clock
    always @(posedge i_sck) begin : shift_in
        int i;
        if (!i_cs_n) begin
            if (bit_n < 32) begin
                cmd_adr = {cmd_adr[30:0], i_mosi};
            end
            bit_n = bit_n + 1;
            if (bit_n == 32) begin
                if (cmd_adr[31:24] != soc_pkg::FLASH_READ_CMD) begin
                    o_bad_cmd <= 1'b1;
                end
                // Byte at a is the low address byte XOR 5a
                for (i = 0; i < 4; i++) begin
                    word = {word[23:0], (cmd_adr[7:0] + 8'(i)) ^ 8'h5a};
                end
            end
        end
    end

    // Data changes on the falling clock, stable for the next rise
    always @(negedge i_sck) begin
        if (!i_cs_n && bit_n >= 32 && bit_n < 64) begin
            o_miso <= word[63 - bit_n];
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_soc_periph.sv
// Peripheral fabric testbench
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;

    typedef enum {K_DATA, K_FETCH, K_BOTH} kind_t;

    logic               ck = 1'b0;
    logic               RESET_LOOP;
    soc_pkg::bus_addr_t i_dbus_adr;
    soc_pkg::bus_data_t i_dbus_dat;
    soc_pkg::bus_sel_t  i_dbus_sel;
    logic               i_dbus_we;
    logic               i_dbus_cyc;
    soc_pkg::bus_data_t o_dbus_rdt;
    logic               o_dbus_ack;
    soc_pkg::bus_addr_t i_ibus_adr;
    logic               i_ibus_cyc;
    soc_pkg::bus_data_t o_ibus_rdt;
    logic               o_ibus_ack;
    soc_pkg::gpio_t     o_gpio;
    logic               o_uart_tx;
    logic               o_flash_sck;
    logic               o_flash_cs_n;
    logic               o_flash_mosi;
    logic               i_flash_miso;
    logic               flash_bad_cmd;

    // Access table, one entry per test
    kind_t               row_kind[$];
    logic                row_we[$];
    soc_pkg::bus_addr_t  row_adr[$];
    soc_pkg::bus_data_t  row_dat[$];
    soc_pkg::bus_data_t  row_exp[$];
    soc_pkg::bus_addr_t  row_iadr[$];
    soc_pkg::bus_data_t  row_iexp[$];
    logic                row_hold[$];
    string               row_name[$];
    logic                rows_ready = 1'b0;

    soc_pkg::uart_byte_t uart_exp[$];
    int                  uart_bytes = 0;
    int                  frames_done = 0;
    int                  cycle = 0;
    int                  errors = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    logic [31:0]         lcg_state;

    soc_periph_top dut0 (.*);

    spi_flash_model flash0 (
        .i_sck     (o_flash_sck),
        .i_cs_n    (o_flash_cs_n),
        .i_mosi    (o_flash_mosi),
        .o_miso    (i_flash_miso),
        .o_bad_cmd (flash_bad_cmd)
    );

    always #20 ck = ~ck;

    always @(posedge ck) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Four flash bytes from address a, first byte on top
    function automatic soc_pkg::bus_data_t flash_word(input soc_pkg::flash_addr_t a);
        return {a[7:0] ^ 8'h5a, (a[7:0] + 8'd1) ^ 8'h5a,
                (a[7:0] + 8'd2) ^ 8'h5a, (a[7:0] + 8'd3) ^ 8'h5a};
    endfunction

    task automatic add_row(input kind_t kind, input logic we, input soc_pkg::bus_addr_t adr,
                           input soc_pkg::bus_data_t dat, input soc_pkg::bus_data_t rd_exp,
                           input soc_pkg::bus_addr_t iadr, input logic hold,
                           input string name);
        row_kind.push_back(kind);
        row_we.push_back(we);
        row_adr.push_back(adr);
        row_dat.push_back(dat);
        row_exp.push_back(rd_exp);
        row_iadr.push_back(iadr);
        row_iexp.push_back(flash_word(iadr[23:0]));
        row_hold.push_back(hold);
        row_name.push_back(name);
        if (kind == K_DATA && we && adr[31:24] == soc_pkg::UART_BASE) begin
            uart_bytes++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    // Runs one table entry on the data bus, the fetch bus or both
    task automatic run_access(input int r, output soc_pkg::bus_data_t d_rdt,
                              output soc_pkg::bus_data_t i_rdt, output int d_at,
                              output int i_at);
        logic d_hit;
        logic i_hit;
        d_rdt = '0;
        i_rdt = '0;
        d_at  = 0;
        i_at  = 0;
        @(posedge ck);
        #5;
        if (row_kind[r] != K_FETCH) begin
            i_dbus_adr = row_adr[r];
            i_dbus_dat = row_dat[r];
            i_dbus_we  = row_we[r];
            i_dbus_cyc = 1'b1;
        end
        if (row_kind[r] != K_DATA) begin
            i_ibus_adr = row_iadr[r];
            i_ibus_cyc = 1'b1;
        end
        // Each bus drops cyc in the cycle after its own ack
        while (i_dbus_cyc || i_ibus_cyc) begin
            @(negedge ck);
            d_hit = i_dbus_cyc && o_dbus_ack;
            i_hit = i_ibus_cyc && o_ibus_ack;
            if (d_hit) begin
                d_rdt = o_dbus_rdt;
                d_at  = cycle;
            end
            if (i_hit) begin
                i_rdt = o_ibus_rdt;
                i_at  = cycle;
            end
            @(posedge ck);
            #5;
            if (d_hit) begin
                i_dbus_cyc = 1'b0;
            end
            if (i_hit) begin
                i_ibus_cyc = 1'b0;
            end
        end
    endtask

    // Samples each UART bit near its middle
    always begin : uart_monitor
        soc_pkg::uart_byte_t got;
        soc_pkg::uart_byte_t want;
        logic                start_bit;
        logic                stop_bit;
        int                  err_before;
        int                  i;
        @(negedge ck);
        if (RESET_LOOP === 1'b0 && o_uart_tx === 1'b0) begin
            err_before = errors;
            repeat (soc_pkg::UART_DIVIDE / 2 - 1) @(negedge ck);
            start_bit = o_uart_tx;
            for (i = 0; i < 8; i++) begin
                repeat (soc_pkg::UART_DIVIDE) @(negedge ck);
                got[i] = o_uart_tx;
            end
            repeat (soc_pkg::UART_DIVIDE) @(negedge ck);
            stop_bit = o_uart_tx;
            if (start_bit !== 1'b0) begin
                $display("FAILED t=%0t o_uart_tx start bit: got %b expected 0", $time, start_bit);
                errors++;
            end
            if (stop_bit !== 1'b1) begin
                $display("FAILED t=%0t o_uart_tx stop bit: got %b expected 1", $time, stop_bit);
                errors++;
            end
            if (uart_exp.size() == 0) begin
                $display("A UART frame was sent although no byte was written");
                errors++;
            end else begin
                want = uart_exp.pop_front();
                if (got !== want) begin
                    $display("FAILED t=%0t o_uart_tx byte: got %02h expected %02h",
                             $time, got, want);
                    errors++;
                end
            end
            frames_done++;
            report_test($sformatf("uart frame %02h", got), err_before);
        end
    end

    initial begin : watchdog
        int limit;
        wait (rows_ready);
        // Reset time plus a budget per entry and per UART byte
        limit = 10 + row_kind.size() * 300 + 12 * soc_pkg::UART_DIVIDE * uart_bytes;
        repeat (limit) @(posedge ck);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main_seq
        soc_pkg::bus_data_t rv;
        soc_pkg::bus_data_t iv;
        soc_pkg::gpio_t     gv;
        soc_pkg::gpio_t     gpio_model;
        soc_pkg::bus_data_t d_rdt;
        soc_pkg::bus_data_t i_rdt;
        soc_pkg::bus_addr_t uart_adr;
        int                 d_at;
        int                 i_at;
        int                 uart_at;
        int                 err_before;
        int                 r;
        int                 k;
        logic               uart_wr;

        RESET_LOOP = 1'b1;
        i_dbus_adr = '0;
        i_dbus_dat = '0;
        i_dbus_sel = 4'hf;
        i_dbus_we  = 1'b0;
        i_dbus_cyc = 1'b0;
        i_ibus_adr = '0;
        i_ibus_cyc = 1'b0;
        lcg_state  = 32'hd4ef;
        gpio_model = '0;
        uart_at    = 0;
        gv         = '0;
        uart_adr   = {soc_pkg::UART_BASE, 24'h0};

        add_row(K_DATA, 1'b0, uart_adr, '0, 32'h0, '0, 1'b0, "uart status idle");
        for (k = 0; k < 3; k++) begin
            rv = lcg_next();
            gv = rv[7:0];
            add_row(K_DATA, 1'b1, {soc_pkg::GPIO_BASE, 24'h0}, rv, '0, '0, 1'b0, "gpio write");
            add_row(K_DATA, 1'b0, {soc_pkg::GPIO_BASE, 24'h0}, '0, {24'h0, gv}, '0, 1'b0,
                    "gpio read");
        end
        rv = lcg_next();
        add_row(K_DATA, 1'b1, uart_adr, rv, '0, '0, 1'b0, "uart frame write");
        rv = lcg_next();
        add_row(K_DATA, 1'b1, uart_adr, rv, '0, '0, 1'b0, "uart write before status");
        add_row(K_DATA, 1'b0, uart_adr + 32'h4, '0, 32'h1, '0, 1'b0, "uart status busy");
        rv = lcg_next();
        add_row(K_DATA, 1'b1, uart_adr, rv, '0, '0, 1'b1, "uart write held");
        for (k = 0; k < 3; k++) begin
            rv = lcg_next();
            add_row(K_DATA, 1'b0, {soc_pkg::FLASH_BASE, rv[23:0]}, '0, flash_word(rv[23:0]),
                    '0, 1'b0, "flash read dbus");
        end
        iv = lcg_next();
        add_row(K_FETCH, 1'b0, '0, '0, '0, {soc_pkg::FLASH_BASE, iv[23:0]}, 1'b0,
                "flash fetch ibus");
        rv = lcg_next();
        iv = lcg_next();
        add_row(K_BOTH, 1'b0, {soc_pkg::FLASH_BASE, rv[23:0]}, '0, flash_word(rv[23:0]),
                {soc_pkg::FLASH_BASE, iv[23:0]}, 1'b0, "fetch priority");
        add_row(K_DATA, 1'b0, 32'h5000_0010, '0, 32'h0, '0, 1'b0, "unmapped read");
        add_row(K_DATA, 1'b1, 32'h5000_0010, 32'hffff_ffff, '0, '0, 1'b0, "unmapped write");
        add_row(K_DATA, 1'b0, {soc_pkg::GPIO_BASE, 24'h0}, '0, {24'h0, gv}, '0, 1'b0,
                "gpio after unmapped");
        rows_ready = 1'b1;

        repeat (10) @(posedge ck);
        #5;
        RESET_LOOP = 1'b0;
        @(negedge ck);
        err_before = errors;
        // Acks low, UART line and chip select high, SCK low, GPIO clear
        if ({o_dbus_ack, o_ibus_ack, o_uart_tx, o_flash_cs_n, o_flash_sck, o_gpio} !==
            {2'b00, 2'b11, 1'b0, 8'h00}) begin
            $display("FAILED t=%0t reset outputs: got %b expected %b", $time,
                     {o_dbus_ack, o_ibus_ack, o_uart_tx, o_flash_cs_n, o_flash_sck, o_gpio},
                     {2'b00, 2'b11, 1'b0, 8'h00});
            errors++;
        end
        report_test("reset outputs", err_before);

        for (r = 0; r < row_kind.size(); r++) begin
            err_before = errors;
            uart_wr = row_kind[r] == K_DATA && row_we[r] &&
                      row_adr[r][31:24] == soc_pkg::UART_BASE;
            if (uart_wr) begin
                uart_exp.push_back(row_dat[r][7:0]);
            end
            run_access(r, d_rdt, i_rdt, d_at, i_at);
            if (row_kind[r] != K_FETCH && !row_we[r] && d_rdt !== row_exp[r]) begin
                $display("FAILED t=%0t o_dbus_rdt: got %h expected %h", $time, d_rdt,
                         row_exp[r]);
                errors++;
            end
            if (row_kind[r] == K_DATA && row_we[r] &&
                row_adr[r][31:24] == soc_pkg::GPIO_BASE) begin
                gpio_model = row_dat[r][7:0];
            end
            if (o_gpio !== gpio_model) begin
                $display("FAILED t=%0t o_gpio: got %h expected %h", $time, o_gpio, gpio_model);
                errors++;
            end
            if (row_kind[r] != K_DATA && i_rdt !== row_iexp[r]) begin
                $display("FAILED t=%0t o_ibus_rdt: got %h expected %h", $time, i_rdt,
                         row_iexp[r]);
                errors++;
            end
            if (row_kind[r] == K_BOTH && i_at >= d_at) begin
                $display("The data bus ack came before the fetch bus ack");
                errors++;
            end
            // A held write may only complete once the earlier frame has ended
            if (row_hold[r] && d_at - uart_at < 10 * soc_pkg::UART_DIVIDE + 1) begin
                $display("A UART write was acknowledged while the previous frame was running");
                errors++;
            end
            if (uart_wr) begin
                uart_at = d_at;
            end
            report_test(row_name[r], err_before);
        end

        while (frames_done < uart_bytes) begin
            @(negedge ck);
        end
        if (flash_bad_cmd) begin
            $display("The flash model received a command other than the read opcode");
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
